// ==== design/lidar_pkg.sv ====
package lidar_pkg;

  // Host command bytes, ASCII S, P, E and R
  localparam logic [7:0] cmd_start = 8'h53;
  localparam logic [7:0] cmd_pause = 8'h50;
  localparam logic [7:0] cmd_stop  = 8'h45;
  localparam logic [7:0] cmd_reset = 8'h52;

  // Record field widths
  localparam int frame_w = 4;
  localparam int line_w  = 6;
  localparam int pixel_w = 6;
  localparam int time_w  = 16;

  // Time code sent when no echo arrives inside the range window
  localparam logic [time_w-1:0] no_echo_time = '1;

  // One scan record, 32 bits, frame in the top bits
  typedef struct packed {
    logic [frame_w-1:0] frame;
    logic [line_w-1:0]  line;
    logic [pixel_w-1:0] pixel;
    logic [time_w-1:0]  tof;
  } scan_record_t;

  // Finished flight-time measurement
  typedef struct packed {
    logic              valid;
    logic [time_w-1:0] tof;
  } meas_t;

endpackage

// ==== design/lidar_top.sv ====
`timescale 1ns/1ps

module lidar_top #(
  // Defaults for a 50 MHz board clock
  parameter int SHOT_PERIOD     = 50000,
  parameter int MAX_RANGE       = 1000,
  parameter int PIXELS_PER_LINE = 64,
  parameter int LINES_PER_FRAME = 16,
  parameter int FIFO_WIDTH      = 7,
  parameter int CLK_PER_BIT     = 12
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_data,
  input  logic       new_rx_data,
  input  logic       echo,
  input  logic       tx_block,
  output logic       enable,
  output logic       shot,
  output logic       new_line,
  output logic       new_frame,
  output logic       serial_out
);

  logic                    pause;
  logic                    soft_reset;
  logic                    fifo_full;
  logic                    fifo_empty;
  logic                    wr_en;
  logic                    rd_en;
  lidar_pkg::meas_t        meas;
  lidar_pkg::scan_record_t wr_record;
  lidar_pkg::scan_record_t head_record;

  main_control u_main_control (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .enable      (enable),
    .pause       (pause),
    .soft_reset  (soft_reset)
  );

  shot_timer #(
    .SHOT_PERIOD (SHOT_PERIOD),
    .MAX_RANGE   (MAX_RANGE)
  ) u_shot_timer (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .pause      (pause),
    .soft_reset (soft_reset),
    .echo       (echo),
    .fifo_full  (fifo_full),
    .shot       (shot),
    .meas       (meas)
  );

  scan_position #(
    .PIXELS_PER_LINE (PIXELS_PER_LINE),
    .LINES_PER_FRAME (LINES_PER_FRAME)
  ) u_scan_position (
    .clk        (clk),
    .rst        (rst),
    .soft_reset (soft_reset),
    .meas       (meas),
    .wr_en      (wr_en),
    .record     (wr_record),
    .new_line   (new_line),
    .new_frame  (new_frame)
  );

  // Soft reset also drops whatever is still queued
  record_fifo #(
    .FIFO_WIDTH (FIFO_WIDTH)
  ) u_record_fifo (
    .clk     (clk),
    .rst     (rst),
    .clear   (soft_reset),
    .wr_en   (wr_en),
    .wr_data (wr_record),
    .rd_en   (rd_en),
    .rd_data (head_record),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

  serial_tx #(
    .CLK_PER_BIT (CLK_PER_BIT)
  ) u_serial_tx (
    .clk        (clk),
    .rst        (rst),
    .record     (head_record),
    .empty      (fifo_empty),
    .tx_block   (tx_block),
    .rd_en      (rd_en),
    .serial_out (serial_out)
  );

endmodule

// ==== design/main_control.sv ====
`timescale 1ns/1ps

module main_control (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] rx_data,
  input  logic       new_rx_data,
  output logic       enable,
  output logic       pause,
  output logic       soft_reset
);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_paused
  } state_t;

  state_t state;

  // Command decoder, unknown bytes fall through untouched
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_idle;
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= 1'b0;
      if (new_rx_data) begin
        case (rx_data)
          lidar_pkg::cmd_start: begin
            state <= st_run;
          end
          lidar_pkg::cmd_pause: begin
            // Only a running scan can be paused
            if (state == st_run) begin
              state <= st_paused;
            end
          end
          lidar_pkg::cmd_stop: begin
            state <= st_idle;
          end
          lidar_pkg::cmd_reset: begin
            soft_reset <= 1'b1;
            state      <= st_idle;
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Acquisition stays enabled while paused
  assign enable = (state != st_idle);
  assign pause  = (state == st_paused);

endmodule

// ==== design/record_fifo.sv ====
`timescale 1ns/1ps

module record_fifo #(
  parameter int FIFO_WIDTH = 7
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clear,
  input  logic                    wr_en,
  input  lidar_pkg::scan_record_t wr_data,
  input  logic                    rd_en,
  output lidar_pkg::scan_record_t rd_data,
  output logic                    full,
  output logic                    empty
);

  localparam int depth = 2 ** FIFO_WIDTH;

  lidar_pkg::scan_record_t mem [depth];

  logic [FIFO_WIDTH-1:0] wr_ptr;
  logic [FIFO_WIDTH-1:0] rd_ptr;
  logic [FIFO_WIDTH:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Count reaches exactly depth when full, so its top bit is the flag
  assign full    = count[FIFO_WIDTH];
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== design/scan_position.sv ====
`timescale 1ns/1ps

module scan_position #(
  parameter int PIXELS_PER_LINE = 64,
  parameter int LINES_PER_FRAME = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    soft_reset,
  input  lidar_pkg::meas_t        meas,
  output logic                    wr_en,
  output lidar_pkg::scan_record_t record,
  output logic                    new_line,
  output logic                    new_frame
);

  logic [lidar_pkg::pixel_w-1:0] pixel;
  logic [lidar_pkg::line_w-1:0]  line;
  logic [lidar_pkg::frame_w-1:0] frame;
  logic                          pixel_wrap;
  logic                          line_wrap;

  assign pixel_wrap = (int'(pixel) == PIXELS_PER_LINE - 1);
  assign line_wrap  = (int'(line) == LINES_PER_FRAME - 1);

  // Mirror position, advances once per measurement
  always_ff @(posedge clk) begin
    if (rst || soft_reset) begin
      pixel     <= '0;
      line      <= '0;
      frame     <= '0;
      wr_en     <= 1'b0;
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      wr_en     <= meas.valid;
      new_line  <= meas.valid && pixel_wrap;
      new_frame <= meas.valid && pixel_wrap && line_wrap;
      if (meas.valid) begin
        pixel <= pixel_wrap ? '0 : pixel + 1'b1;
        if (pixel_wrap) begin
          line <= line_wrap ? '0 : line + 1'b1;
          // Frame number simply rolls over at 16
          if (line_wrap) begin
            frame <= frame + 1'b1;
          end
        end
      end
    end
  end

  // Tag the measurement with the position it was taken at
  always_ff @(posedge clk) begin
    if (meas.valid) begin
      record.frame <= frame;
      record.line  <= line;
      record.pixel <= pixel;
      record.tof   <= meas.tof;
    end
  end

endmodule

// ==== design/serial_tx.sv ====
`timescale 1ns/1ps

module serial_tx #(
  parameter int CLK_PER_BIT = 12
) (
  input  logic                    clk,
  input  logic                    rst,
  input  lidar_pkg::scan_record_t record,
  input  logic                    empty,
  input  logic                    tx_block,
  output logic                    rd_en,
  output logic                    serial_out
);

  localparam int cnt_w = (CLK_PER_BIT > 1) ? $clog2(CLK_PER_BIT) : 1;

  logic [cnt_w-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [1:0]       byte_idx;
  logic [8:0]       shifter;
  logic             busy;
  logic             start_byte;
  logic [7:0]       tx_byte;

  // Byte order on the wire
  always_comb begin
    case (byte_idx)
      // Frame in the high nibble, low four line bits below it
      2'd0:    tx_byte = {record.frame, record.line[3:0]};
      2'd1:    tx_byte = {2'b00, record.pixel};
      2'd2:    tx_byte = record.tof[15:8];
      default: tx_byte = record.tof[7:0];
    endcase
  end

  // Host busy is only looked at between bytes
  assign start_byte = !busy && !empty && !tx_block;
  // Last byte is already in the shifter, so the head can go
  assign rd_en      = start_byte && (byte_idx == 2'd3);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      byte_idx   <= 2'd0;
      clk_cnt    <= '0;
      bit_cnt    <= 4'd0;
      serial_out <= 1'b1;
    end else if (!busy) begin
      if (start_byte) begin
        busy       <= 1'b1;
        shifter    <= {1'b1, tx_byte};
        serial_out <= 1'b0;
        clk_cnt    <= '0;
        bit_cnt    <= 4'd0;
      end else if (empty) begin
        // FIFO was cleared under a partial record, start over
        byte_idx <= 2'd0;
      end
    end else if (int'(clk_cnt) == CLK_PER_BIT - 1) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        // Stop bit done
        busy     <= 1'b0;
        byte_idx <= byte_idx + 1'b1;
      end else begin
        serial_out <= shifter[0];
        shifter    <= {1'b1, shifter[8:1]};
        bit_cnt    <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

// ==== design/shot_timer.sv ====
`timescale 1ns/1ps

module shot_timer #(
  parameter int SHOT_PERIOD = 50000,
  parameter int MAX_RANGE   = 1000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,
  input  logic              pause,
  input  logic              soft_reset,
  input  logic              echo,
  input  logic              fifo_full,
  output logic              shot,
  output lidar_pkg::meas_t  meas
);

  localparam int period_w = $clog2(SHOT_PERIOD);

  logic [period_w-1:0]          period_cnt;
  logic [lidar_pkg::time_w-1:0] flight_cnt;
  logic                         in_flight;
  logic                         settle;
  logic                         running;
  logic                         elapsed;
  logic                         pending;

  assign running = enable && !pause;
  assign elapsed = (int'(period_cnt) == SHOT_PERIOD - 1);
  // Busy until the record has landed in the FIFO and full is up to date
  assign pending = in_flight || meas.valid || settle;
  assign shot    = elapsed && running && !fifo_full && !pending;

  // Period counter holds at the end until a shot can go out
  always_ff @(posedge clk) begin
    if (rst || soft_reset || !enable || shot) begin
      period_cnt <= '0;
    end else if (running && !elapsed) begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // Coarse TDC, counts cycles from the shot to the first echo
  always_ff @(posedge clk) begin
    if (rst || soft_reset) begin
      in_flight  <= 1'b0;
      settle     <= 1'b0;
      meas.valid <= 1'b0;
    end else begin
      meas.valid <= 1'b0;
      settle     <= meas.valid;
      if (shot) begin
        in_flight  <= 1'b1;
        flight_cnt <= {{(lidar_pkg::time_w-1){1'b0}}, 1'b1};
      end else if (in_flight) begin
        if (echo) begin
          meas.valid <= 1'b1;
          meas.tof   <= flight_cnt;
          in_flight  <= 1'b0;
        end else if (int'(flight_cnt) == MAX_RANGE) begin
          meas.valid <= 1'b1;
          meas.tof   <= lidar_pkg::no_echo_time;
          in_flight  <= 1'b0;
        end else begin
          flight_cnt <= flight_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module lidar_tb -f sources.f -o lidar_sim \
  && ./obj_dir/lidar_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"

// ==== sources.f ====
design/lidar_pkg.sv
design/main_control.sv
design/shot_timer.sv
design/scan_position.sv
design/record_fifo.sv
design/serial_tx.sv
design/lidar_top.sv
verification/lidar_assert.sv
verification/lidar_tb.sv

// ==== verification/lidar_assert.sv ====
`timescale 1ns/1ps

module lidar_assert (
  input logic       clk,
  input logic       rst,
  input logic [7:0] rx_data,
  input logic       new_rx_data,
  input logic       enable,
  input logic       pause,
  input logic       shot,
  input logic       wr_en,
  input logic       fifo_full,
  input logic       serial_out
);

  logic stop_cmd;
  logic pause_cmd;

  assign stop_cmd  = new_rx_data &&
                     (rx_data == lidar_pkg::cmd_stop || rx_data == lidar_pkg::cmd_reset);
  assign pause_cmd = new_rx_data && (rx_data == lidar_pkg::cmd_pause) && enable;

  // Stop or reset command halts the shot path on the next clock
  a_stop_halts: assert property (@(posedge clk) disable iff (rst)
    stop_cmd |=> !enable && !shot)
    else $error("shot or enable still up after a stop command");

  // Pause command freezes an enabled scan
  a_pause_holds: assert property (@(posedge clk) disable iff (rst)
    pause_cmd |=> pause && !shot)
    else $error("scan not paused after a pause command");

  a_no_write_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !fifo_full)
    else $error("FIFO written while full");

  // Line idles high out of reset
  a_idle_in_reset: assert property (@(posedge clk) rst |=> serial_out)
    else $error("serial_out low during reset");

endmodule

bind lidar_top lidar_assert u_lidar_assert (
  .clk         (clk),
  .rst         (rst),
  .rx_data     (rx_data),
  .new_rx_data (new_rx_data),
  .enable      (enable),
  .pause       (pause),
  .shot        (shot),
  .wr_en       (wr_en),
  .fifo_full   (fifo_full),
  .serial_out  (serial_out)
);

// ==== verification/lidar_tb.sv ====
`timescale 1ns/1ps

module lidar_tb;

  localparam int SHOT_PERIOD     = 300;
  localparam int MAX_RANGE       = 100;
  localparam int PIXELS_PER_LINE = 5;
  localparam int LINES_PER_FRAME = 3;
  localparam int FIFO_WIDTH      = 2;
  localparam int CLK_PER_BIT     = 4;
  // Cycle budget for the shot phases, blocked phases and drains
  localparam int test_cycles     = 70 * SHOT_PERIOD + 6 * (3000 + 1200) + 3000;
  localparam int watchdog_cycles = test_cycles + 20000;

  logic       clk = 1'b0;
  logic       rst;
  logic [7:0] rx_data;
  logic       new_rx_data;
  logic       echo;
  logic       tx_block;
  logic       enable;
  logic       shot;
  logic       new_line;
  logic       new_frame;
  logic       serial_out;

  logic [31:0]             rng = 32'h90ac_4b9a;
  lidar_pkg::scan_record_t exp_q[$];
  int m_pixel      = 0;
  int m_line       = 0;
  int m_frame      = 0;
  int line_wraps   = 0;
  int frame_wraps  = 0;
  int line_pulses  = 0;
  int frame_pulses = 0;
  int shot_count   = 0;
  int rx_byte_idx  = 0;
  logic full_seen  = 1'b0;

  lidar_top #(
    .SHOT_PERIOD     (SHOT_PERIOD),
    .MAX_RANGE       (MAX_RANGE),
    .PIXELS_PER_LINE (PIXELS_PER_LINE),
    .LINES_PER_FRAME (LINES_PER_FRAME),
    .FIFO_WIDTH      (FIFO_WIDTH),
    .CLK_PER_BIT     (CLK_PER_BIT)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .rx_data     (rx_data),
    .new_rx_data (new_rx_data),
    .echo        (echo),
    .tx_block    (tx_block),
    .enable      (enable),
    .shot        (shot),
    .new_line    (new_line),
    .new_frame   (new_frame),
    .serial_out  (serial_out)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int span);
    rng = xorshift(rng);
    return int'(rng % 32'(span));
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic send_cmd(input logic [7:0] value);
    @(negedge clk);
    rx_data     = value;
    new_rx_data = 1'b1;
    @(negedge clk);
    new_rx_data = 1'b0;
  endtask

  task automatic wait_shots(input int n);
    int target;
    target = shot_count + n;
    while (shot_count < target) begin
      @(negedge clk);
    end
  endtask

  // Let the last flight finish, then wait for the decoder to catch up
  task automatic drain_records();
    repeat (MAX_RANGE + 30) @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // Echo responder and reference model with one entry per shot
  initial begin : echo_responder
    int delay;
    lidar_pkg::scan_record_t rec;
    forever begin
      @(negedge clk);
      if (!rst && shot === 1'b1) begin
        shot_count++;
        delay     = 1 + rand_below(120);
        rec.frame = 4'(m_frame);
        rec.line  = 6'(m_line);
        rec.pixel = 6'(m_pixel);
        rec.tof   = (delay > MAX_RANGE) ? lidar_pkg::no_echo_time : 16'(delay);
        exp_q.push_back(rec);
        if (m_pixel == PIXELS_PER_LINE - 1) begin
          m_pixel = 0;
          line_wraps++;
          if (m_line == LINES_PER_FRAME - 1) begin
            m_line = 0;
            frame_wraps++;
            m_frame = (m_frame + 1) % 16;
          end else begin
            m_line++;
          end
        end else begin
          m_pixel++;
        end
        // Late echoes are still driven and must be ignored
        repeat (delay) @(negedge clk);
        echo = 1'b1;
        @(negedge clk);
        echo = 1'b0;
      end
    end
  end

  // 8N1 decoder sampling near mid-bit
  initial begin : serial_decoder
    logic [7:0] rx_bytes [4];
    lidar_pkg::scan_record_t got;
    lidar_pkg::scan_record_t want;
    forever begin
      @(negedge clk);
      if (!rst && serial_out === 1'b0) begin
        repeat (CLK_PER_BIT / 2 - 1) @(negedge clk);
        check_value(serial_out, 1'b0, "start bit");
        for (int i = 0; i < 8; i++) begin
          repeat (CLK_PER_BIT) @(negedge clk);
          rx_bytes[rx_byte_idx][i] = serial_out;
        end
        repeat (CLK_PER_BIT) @(negedge clk);
        check_value(serial_out, 1'b1, "stop bit");
        if (rx_byte_idx == 3) begin
          rx_byte_idx = 0;
          check_value(rx_bytes[1][7:6], 2'b00, "pixel byte top bits");
          got.frame = rx_bytes[0][7:4];
          got.line  = {2'b00, rx_bytes[0][3:0]};
          got.pixel = rx_bytes[1][5:0];
          got.tof   = {rx_bytes[2], rx_bytes[3]};
          if (exp_q.size() == 0) begin
            abort_run("A record came out of the serial line with no shot behind it");
          end else begin
            want = exp_q.pop_front();
            check_value(got, want, "decoded record");
          end
        end else begin
          rx_byte_idx++;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (new_line === 1'b1) begin
        line_pulses++;
      end
      if (new_frame === 1'b1) begin
        frame_pulses++;
      end
      if (u_dut.fifo_full === 1'b1) begin
        full_seen = 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("Watchdog expired before all test phases finished");
  end

  initial begin : stimulus
    logic [7:0] junk;
    int snap;
    rst         = 1'b1;
    rx_data     = 8'h00;
    new_rx_data = 1'b0;
    echo        = 1'b0;
    tx_block    = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // Top bit set keeps the junk bytes off the command codes
    for (int n = 0; n < 20; n++) begin
      junk = 8'(rand_below(256)) | 8'h80;
      send_cmd(junk);
      repeat (3) @(negedge clk);
      check_value(enable, 1'b0, "enable while idle");
      check_value(shot, 1'b0, "shot while idle");
      check_value({new_line, new_frame}, 2'b00, "scan pulses while idle");
      check_value(serial_out, 1'b1, "idle serial line");
    end

    send_cmd(lidar_pkg::cmd_start);
    wait_shots(40);
    send_cmd(lidar_pkg::cmd_stop);
    drain_records();
    check_value(line_pulses, line_wraps, "new_line count");
    check_value(frame_pulses, frame_wraps, "new_frame count");

    // Pause holds shots back and start resumes the scan
    send_cmd(lidar_pkg::cmd_start);
    wait_shots(10);
    send_cmd(lidar_pkg::cmd_pause);
    repeat (2) @(negedge clk);
    snap = shot_count;
    repeat (5 * SHOT_PERIOD) @(negedge clk);
    check_value(shot_count, snap, "shots during pause");
    check_value(enable, 1'b1, "enable while paused");
    send_cmd(lidar_pkg::cmd_start);
    wait_shots(5);
    send_cmd(lidar_pkg::cmd_stop);
    check_value(enable, 1'b0, "enable after stop");
    drain_records();

    // Host back-pressure long enough to fill the FIFO
    send_cmd(lidar_pkg::cmd_start);
    for (int r = 0; r < 6; r++) begin
      tx_block = 1'b1;
      repeat (1500 + rand_below(1501)) @(negedge clk);
      tx_block = 1'b0;
      repeat (200 + rand_below(1000)) @(negedge clk);
    end
    send_cmd(lidar_pkg::cmd_stop);
    drain_records();
    check_value(full_seen, 1'b1, "FIFO full seen");

    // Soft reset with records still queued
    send_cmd(lidar_pkg::cmd_start);
    wait_shots(3);
    tx_block = 1'b1;
    wait_shots(2);
    send_cmd(lidar_pkg::cmd_stop);
    repeat (200) @(negedge clk);
    send_cmd(lidar_pkg::cmd_reset);
    repeat (2) @(negedge clk);
    exp_q.delete();
    m_pixel     = 0;
    m_line      = 0;
    m_frame     = 0;
    rx_byte_idx = 0;
    check_value(u_dut.fifo_empty, 1'b1, "FIFO empty after reset command");
    check_value(enable, 1'b0, "enable after reset command");
    tx_block = 1'b0;
    send_cmd(lidar_pkg::cmd_start);
    wait_shots(6);
    send_cmd(lidar_pkg::cmd_stop);
    drain_records();
    check_value(line_pulses, line_wraps, "final new_line count");
    check_value(frame_pulses, frame_wraps, "final new_frame count");

    $display("TEST OK");
    $finish;
  end

endmodule
